// ==== hdl/soc_pkg.sv ====
//////////////////////////////////////////////////
// Peripheral subsystem constants
// Bus widths, slot map, register offsets and the
// timing values shared by the peripherals
//////////////////////////////////////////////////

package soc_pkg;

	// Bus
	localparam int WB_DW = 32;
	localparam int WB_AW = 16;

	// Slot select bits of the word address
	localparam int SLOT_MSB = 14;
	localparam int SLOT_LSB = 12;
	localparam int SLOT_W   = SLOT_MSB - SLOT_LSB + 1;
	localparam int SLV_AW   = SLOT_LSB;

	localparam logic [SLOT_W-1:0] SLOT_BOOT = 3'd0;
	localparam logic [SLOT_W-1:0] SLOT_UART = 3'd1;
	localparam logic [SLOT_W-1:0] SLOT_LED  = 3'd3;
	localparam logic [SLOT_W-1:0] SLOT_EP   = 3'd5;

	// Slave index on the decoder side
	localparam int SLV_N    = 4;
	localparam int SLV_BOOT = 0;
	localparam int SLV_UART = 1;
	localparam int SLV_LED  = 2;
	localparam int SLV_EP   = 3;

	// UART
	localparam int UART_DIV_W = 12;
	localparam logic [1:0] UART_REG_DATA = 2'd0;
	localparam logic [1:0] UART_REG_DIV  = 2'd1;

	// Endpoint buffer
	localparam int EP_AW     = 9;
	localparam int EP_RX_SEL = 9;

	// LED
	localparam int PWM_W       = 8;
	localparam int LED_CTRL_W  = 5;
	localparam int LED_CTRL_EN = 2;

	// Button
	localparam int BTN_DEBOUNCE = 16;
	localparam int BTN_LONG     = 2000;
	localparam logic [1:0] BTN_BOOT_SEL = 2'd1;

endpackage

// ==== hdl/wb_slot_decode.sv ====
//////////////////////////////////////////////////
// Bus slot decoder
// Splits the master cycle into per-slave cycles and
// returns the selected slave's data and ack
//////////////////////////////////////////////////

`timescale 1ns/10ps

module wb_slot_decode import soc_pkg::*; (
	input  logic                        clk_24m,
	input  logic                        rst,
	input  logic [WB_AW-1:0]            wb_addr_i,
	input  logic                        wb_cyc_i,
	output logic [WB_DW-1:0]            wb_rdata_o,
	output logic                        wb_ack_o,
	output logic [SLV_N-1:0]            slv_cyc_o,
	input  logic [SLV_N-1:0][WB_DW-1:0] slv_rdata_i,
	input  logic [SLV_N-1:0]            slv_ack_i
);

	logic [SLOT_W-1:0] slot;
	logic              mapped;
	logic [1:0]        idx;

	assign slot = wb_addr_i[SLOT_MSB:SLOT_LSB];

	always_comb begin
		mapped = 1'b1;
		idx    = 2'(SLV_BOOT);
		case (slot)
			SLOT_BOOT: idx = 2'(SLV_BOOT);
			SLOT_UART: idx = 2'(SLV_UART);
			SLOT_LED:  idx = 2'(SLV_LED);
			SLOT_EP:   idx = 2'(SLV_EP);
			default:   mapped = 1'b0;
		endcase
	end

	always_comb begin
		slv_cyc_o = '0;
		slv_cyc_o[idx] = wb_cyc_i & mapped;
	end

	// Unmapped slots answer at once with zero
	assign wb_ack_o   = wb_cyc_i & (mapped ? slv_ack_i[idx] : 1'b1);
	assign wb_rdata_o = mapped ? slv_rdata_i[idx] : '0;

	// A slave only acks its own cycle
	a_ack_selected: assert property (
		@(posedge clk_24m) disable iff (rst) (slv_ack_i & ~slv_cyc_o) == '0
	);

endmodule

// ==== hdl/uart_wb.sv ====
//////////////////////////////////////////////////
// UART slave
// 8N1 transmitter and receiver, programmable bit
// time and a one-byte receive buffer
//////////////////////////////////////////////////

`timescale 1ns/10ps

module uart_wb import soc_pkg::*; (
	input  logic              clk_24m,
	input  logic              rst,
	input  logic              cyc_i,
	input  logic [SLV_AW-1:0] addr_i,
	input  logic              we_i,
	input  logic [WB_DW-1:0]  wdata_i,
	output logic [WB_DW-1:0]  rdata_o,
	output logic              ack_o,
	input  logic              uart_rx_i,
	output logic              uart_tx_o
);

	logic [UART_DIV_W-1:0] div_q;
	logic [UART_DIV_W:0]   bit_max;
	logic                  sel_data;
	logic                  wr_stb;
	logic                  rd_stb;

	// Transmitter
	logic [9:0]            tx_shift;
	logic [3:0]            tx_bits;
	logic [UART_DIV_W:0]   tx_cnt;
	logic                  tx_busy;
	logic                  tx_start;

	// Receiver
	logic                  rx_meta;
	logic                  rx_s;
	logic                  rx_active;
	logic [3:0]            rx_bits;
	logic [UART_DIV_W:0]   rx_cnt;
	logic                  rx_tick;
	logic                  rx_done;
	logic                  rx_full;
	logic [7:0]            rx_sr;
	logic [7:0]            rx_data;

	// Bit time is div + 2 cycles
	assign bit_max  = {1'b0, div_q} + 1'b1;
	assign sel_data = addr_i[1:0] == UART_REG_DATA;
	assign wr_stb   = cyc_i & ack_o & we_i;
	assign rd_stb   = cyc_i & ack_o & ~we_i;

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			ack_o <= 1'b0;
			div_q <= UART_DIV_W'(2);
		end else begin
			ack_o <= cyc_i & ~ack_o;
			if (wr_stb && addr_i[1:0] == UART_REG_DIV)
				div_q <= wdata_i[UART_DIV_W-1:0];
		end
	end

	always_comb begin
		rdata_o = '0;
		if (sel_data) begin
			rdata_o[WB_DW-1] = ~rx_full;
			rdata_o[WB_DW-2] = tx_busy;
			rdata_o[7:0]     = rx_data;
		end else begin
			rdata_o[UART_DIV_W-1:0] = div_q;
		end
	end

	assign tx_busy   = tx_bits != 4'd0;
	assign tx_start  = wr_stb & sel_data & ~tx_busy;
	assign uart_tx_o = tx_shift[0];

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			tx_shift <= '1;
			tx_bits  <= 4'd0;
			tx_cnt   <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// Stop, data LSB first, start
				tx_shift <= {1'b1, wdata_i[7:0], 1'b0};
				tx_bits  <= 4'd10;
				tx_cnt   <= '0;
			end
		end else if (tx_cnt == bit_max) begin
			tx_cnt   <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_bits  <= tx_bits - 1'b1;
		end else begin
			tx_cnt <= tx_cnt + 1'b1;
		end
	end

	assign rx_tick = rx_active & (rx_cnt == '0);
	assign rx_done = rx_tick & (rx_bits == 4'd9) & rx_s;

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			rx_meta   <= 1'b1;
			rx_s      <= 1'b1;
			rx_active <= 1'b0;
			rx_bits   <= 4'd0;
			rx_cnt    <= '0;
			rx_full   <= 1'b0;
		end else begin
			rx_meta <= uart_rx_i;
			rx_s    <= rx_meta;
			if (rx_done)
				rx_full <= 1'b1;
			else if (rd_stb && sel_data)
				rx_full <= 1'b0;
			if (!rx_active) begin
				if (!rx_s) begin
					// Start edge, wait half a bit
					rx_active <= 1'b1;
					rx_bits   <= 4'd0;
					rx_cnt    <= bit_max >> 1;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= bit_max;
				if ((rx_bits == 4'd0 && rx_s) || rx_bits == 4'd9)
					rx_active <= 1'b0;
				else
					rx_bits <= rx_bits + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_24m) begin
		if (rx_tick && rx_bits != 4'd0 && rx_bits != 4'd9)
			rx_sr <= {rx_s, rx_sr[7:1]};
		if (rx_done)
			rx_data <= rx_sr;
	end

	// Line idles high between frames
	a_tx_idle: assert property (
		@(posedge clk_24m) disable iff (rst) !tx_busy |-> uart_tx_o
	);

endmodule

// ==== hdl/led_pwm_wb.sv ====
//////////////////////////////////////////////////
// RGB LED PWM slave
// Control register, three duty registers and an
// 8-bit free-running PWM generator
//////////////////////////////////////////////////

`timescale 1ns/10ps

module led_pwm_wb import soc_pkg::*; (
	input  logic              clk_24m,
	input  logic              rst,
	input  logic              cyc_i,
	input  logic [SLV_AW-1:0] addr_i,
	input  logic              we_i,
	input  logic [WB_DW-1:0]  wdata_i,
	output logic [WB_DW-1:0]  rdata_o,
	output logic              ack_o,
	output logic [2:0]        rgb_o
);

	logic [LED_CTRL_W-1:0] ctrl_q;
	logic [PWM_W-1:0]      duty_q [3];
	logic [PWM_W-1:0]      pwm_cnt;
	logic                  ctrl_wr;
	logic                  duty_wr;

	assign ack_o   = cyc_i;
	assign rdata_o = {{(WB_DW-LED_CTRL_W){1'b0}}, ctrl_q};

	assign ctrl_wr = cyc_i & we_i & ~addr_i[4];
	assign duty_wr = cyc_i & we_i & addr_i[4] & (addr_i[1:0] != 2'd3);

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			ctrl_q  <= '0;
			pwm_cnt <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			if (ctrl_wr)
				ctrl_q <= wdata_i[LED_CTRL_W-1:0];
		end
	end

	always_ff @(posedge clk_24m) begin
		if (duty_wr)
			duty_q[addr_i[1:0]] <= wdata_i[PWM_W-1:0];
	end

	// High while the counter is below the duty value
	always_comb begin
		for (int i = 0; i < 3; i++)
			rgb_o[i] = ctrl_q[LED_CTRL_EN] & (pwm_cnt < duty_q[i]);
	end

endmodule

// ==== hdl/boot_ctrl_wb.sv ====
//////////////////////////////////////////////////
// Warm-boot control slave
// Boot request register, button debouncer and a
// long-press timer that requests a boot
//////////////////////////////////////////////////

`timescale 1ns/10ps

module boot_ctrl_wb import soc_pkg::*; (
	input  logic              clk_24m,
	input  logic              rst,
	input  logic              cyc_i,
	input  logic [SLV_AW-1:0] addr_i,
	input  logic              we_i,
	input  logic [WB_DW-1:0]  wdata_i,
	output logic [WB_DW-1:0]  rdata_o,
	output logic              ack_o,
	input  logic              btn_i,
	output logic              boot_o,
	output logic [1:0]        boot_sel_o
);

	localparam int DEB_W  = $clog2(BTN_DEBOUNCE);
	localparam int LONG_W = $clog2(BTN_LONG + 1);

	logic              boot_wr;
	logic              btn_meta;
	logic              btn_s;
	logic              btn_db;
	logic [DEB_W-1:0]  deb_cnt;
	logic [LONG_W-1:0] long_cnt;
	logic              long_fire;

	assign ack_o     = cyc_i;
	assign rdata_o   = {{(WB_DW-3){1'b0}}, boot_o, boot_sel_o};
	assign boot_wr   = cyc_i & we_i & (addr_i[2:0] == 3'b000);
	assign long_fire = btn_db & (long_cnt == LONG_W'(BTN_LONG - 1));

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			btn_meta <= 1'b0;
			btn_s    <= 1'b0;
			btn_db   <= 1'b0;
			deb_cnt  <= '0;
			long_cnt <= '0;
		end else begin
			btn_meta <= btn_i;
			btn_s    <= btn_meta;
			if (btn_s == btn_db) begin
				deb_cnt <= '0;
			end else if (deb_cnt == DEB_W'(BTN_DEBOUNCE - 1)) begin
				btn_db  <= btn_s;
				deb_cnt <= '0;
			end else begin
				deb_cnt <= deb_cnt + 1'b1;
			end
			// Saturates so a held button fires once
			if (!btn_db)
				long_cnt <= '0;
			else if (long_cnt != LONG_W'(BTN_LONG))
				long_cnt <= long_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst) begin
			boot_o     <= 1'b0;
			boot_sel_o <= 2'b00;
		end else if (boot_wr) begin
			boot_o     <= wdata_i[2];
			boot_sel_o <= wdata_i[1:0];
		end else if (long_fire) begin
			boot_o     <= 1'b1;
			boot_sel_o <= BTN_BOOT_SEL;
		end
	end

	a_boot_hold: assert property (
		@(posedge clk_24m) disable iff (rst) $fell(boot_o) |-> $past(boot_wr)
	);

endmodule

// ==== hdl/ep_buffer_wb.sv ====
//////////////////////////////////////////////////
// USB endpoint buffer slave
// Transmit and receive RAMs, bus port on one side
// and a USB core port on the other
//////////////////////////////////////////////////

`timescale 1ns/10ps

module ep_buffer_wb import soc_pkg::*; (
	input  logic              clk_24m,
	input  logic              rst,
	input  logic              cyc_i,
	input  logic [SLV_AW-1:0] addr_i,
	input  logic              we_i,
	input  logic [WB_DW-1:0]  wdata_i,
	output logic [WB_DW-1:0]  rdata_o,
	output logic              ack_o,
	input  logic [EP_AW-1:0]  usb_tx_addr_i,
	output logic [WB_DW-1:0]  usb_tx_data_o,
	input  logic [EP_AW-1:0]  usb_rx_addr_i,
	input  logic [WB_DW-1:0]  usb_rx_data_i,
	input  logic              usb_rx_we_i
);

	logic [WB_DW-1:0] tx_ram [2**EP_AW];
	logic [WB_DW-1:0] rx_ram [2**EP_AW];
	logic [WB_DW-1:0] tx_rd;
	logic [WB_DW-1:0] rx_rd;
	logic             rx_sel_q;
	logic             bus_wr;

	always_ff @(posedge clk_24m or posedge rst) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= cyc_i & ~ack_o;
	end

	// Write once, in the first cycle of the transfer
	assign bus_wr = cyc_i & ~ack_o & we_i;

	// Transmit RAM, bus read/write and USB read
	always_ff @(posedge clk_24m) begin
		if (bus_wr)
			tx_ram[addr_i[EP_AW-1:0]] <= wdata_i;
		tx_rd         <= tx_ram[addr_i[EP_AW-1:0]];
		usb_tx_data_o <= tx_ram[usb_tx_addr_i];
	end

	// Receive RAM, USB write and bus read
	always_ff @(posedge clk_24m) begin
		if (usb_rx_we_i)
			rx_ram[usb_rx_addr_i] <= usb_rx_data_i;
		rx_rd    <= rx_ram[addr_i[EP_AW-1:0]];
		rx_sel_q <= addr_i[EP_RX_SEL];
	end

	assign rdata_o = rx_sel_q ? rx_rd : tx_rd;

endmodule

// ==== hdl/soc_periph_top.sv ====
//////////////////////////////////////////////////
// Peripheral subsystem top
// One bus master port fanned out to boot control,
// UART, RGB PWM and the USB endpoint buffer
//////////////////////////////////////////////////

`timescale 1ns/10ps

module soc_periph_top import soc_pkg::*; (
	input  logic             clk_24m,
	input  logic             rst,

	// Bus master port
	input  logic [WB_AW-1:0] wb_addr_i,
	input  logic [WB_DW-1:0] wb_wdata_i,
	input  logic             wb_we_i,
	input  logic             wb_cyc_i,
	output logic [WB_DW-1:0] wb_rdata_o,
	output logic             wb_ack_o,

	// Pins
	input  logic             uart_rx_i,
	output logic             uart_tx_o,
	input  logic             btn_i,
	output logic [2:0]       rgb_o,
	output logic             boot_o,
	output logic [1:0]       boot_sel_o,

	// USB core side of the endpoint buffer
	input  logic [EP_AW-1:0] usb_tx_addr_i,
	output logic [WB_DW-1:0] usb_tx_data_o,
	input  logic [EP_AW-1:0] usb_rx_addr_i,
	input  logic [WB_DW-1:0] usb_rx_data_i,
	input  logic             usb_rx_we_i
);

	logic [SLV_N-1:0]            slv_cyc;
	logic [SLV_N-1:0][WB_DW-1:0] slv_rdata;
	logic [SLV_N-1:0]            slv_ack;

	wb_slot_decode u_decode (
		.clk_24m     (clk_24m),
		.rst         (rst),
		.wb_addr_i   (wb_addr_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_rdata_o  (wb_rdata_o),
		.wb_ack_o    (wb_ack_o),
		.slv_cyc_o   (slv_cyc),
		.slv_rdata_i (slv_rdata),
		.slv_ack_i   (slv_ack)
	);

	boot_ctrl_wb u_boot (
		.clk_24m    (clk_24m),
		.rst        (rst),
		.cyc_i      (slv_cyc[SLV_BOOT]),
		.addr_i     (wb_addr_i[SLV_AW-1:0]),
		.we_i       (wb_we_i),
		.wdata_i    (wb_wdata_i),
		.rdata_o    (slv_rdata[SLV_BOOT]),
		.ack_o      (slv_ack[SLV_BOOT]),
		.btn_i      (btn_i),
		.boot_o     (boot_o),
		.boot_sel_o (boot_sel_o)
	);

	uart_wb u_uart (
		.clk_24m   (clk_24m),
		.rst       (rst),
		.cyc_i     (slv_cyc[SLV_UART]),
		.addr_i    (wb_addr_i[SLV_AW-1:0]),
		.we_i      (wb_we_i),
		.wdata_i   (wb_wdata_i),
		.rdata_o   (slv_rdata[SLV_UART]),
		.ack_o     (slv_ack[SLV_UART]),
		.uart_rx_i (uart_rx_i),
		.uart_tx_o (uart_tx_o)
	);

	led_pwm_wb u_led (
		.clk_24m (clk_24m),
		.rst     (rst),
		.cyc_i   (slv_cyc[SLV_LED]),
		.addr_i  (wb_addr_i[SLV_AW-1:0]),
		.we_i    (wb_we_i),
		.wdata_i (wb_wdata_i),
		.rdata_o (slv_rdata[SLV_LED]),
		.ack_o   (slv_ack[SLV_LED]),
		.rgb_o   (rgb_o)
	);

	ep_buffer_wb u_ep (
		.clk_24m       (clk_24m),
		.rst           (rst),
		.cyc_i         (slv_cyc[SLV_EP]),
		.addr_i        (wb_addr_i[SLV_AW-1:0]),
		.we_i          (wb_we_i),
		.wdata_i       (wb_wdata_i),
		.rdata_o       (slv_rdata[SLV_EP]),
		.ack_o         (slv_ack[SLV_EP]),
		.usb_tx_addr_i (usb_tx_addr_i),
		.usb_tx_data_o (usb_tx_data_o),
		.usb_rx_addr_i (usb_rx_addr_i),
		.usb_rx_data_i (usb_rx_data_i),
		.usb_rx_we_i   (usb_rx_we_i)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock generator
// Free-running clock with a 100 ns period
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_o
);

	localparam int HALF_NS = 50;

	initial begin
		clk_o = 1'b0;
		forever #HALF_NS clk_o = ~clk_o;
	end

endmodule

// ==== dv/tb_soc_periph.sv ====
//////////////////////////////////////////////////
// Peripheral subsystem testbench
// Drives the bus port in place of the CPU, loops
// the UART back and checks with assertions
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_soc_periph import soc_pkg::*; ();

	localparam int DRV_DLY     = 10;
	localparam int CLK_NS      = 100;
	localparam int RST_CYC     = 10;
	localparam int ACK_MAX     = 4;
	localparam int POLL_MAX    = 100;
	localparam int UART_DIV    = 10;
	localparam int LED_OFF_CYC = 300;
	localparam int PWM_WIN     = 2**PWM_W;
	localparam int SHORT_CYC   = BTN_LONG - 100;
	localparam int LONG_MAX    = BTN_LONG + BTN_DEBOUNCE + 20;
	localparam logic [3*PWM_W-1:0] DUTY = {8'd255, 8'd128, 8'd0};

	// Frame plus polling per byte, and the button presses dominate
	localparam int TEST_CYC = 2 * RST_CYC + 80 + 3 * (12 * (UART_DIV + 2) + 60)
		+ LED_OFF_CYC + 3 * PWM_WIN + 60 + SHORT_CYC + 160 + LONG_MAX;
	localparam int WDOG_NS  = TEST_CYC * CLK_NS * 3 / 2;

	logic               clk_24m;
	logic               rst;
	logic [WB_AW-1:0]   wb_addr;
	logic [WB_DW-1:0]   wb_wdata;
	logic               wb_we;
	logic               wb_cyc;
	logic [WB_DW-1:0]   wb_rdata;
	logic               wb_ack;
	logic               uart_line;
	logic               btn;
	logic [2:0]         rgb;
	logic               boot;
	logic [1:0]         boot_sel;
	logic [EP_AW-1:0]   usb_tx_addr;
	logic [WB_DW-1:0]   usb_tx_data;
	logic [EP_AW-1:0]   usb_rx_addr;
	logic [WB_DW-1:0]   usb_rx_data;
	logic               usb_rx_we;

	int                 errors;
	int                 xfers;
	logic [31:0]        lcg_state;
	logic               exp_en;
	logic [WB_DW-1:0]   exp_mask;
	logic [WB_DW-1:0]   exp_val;
	logic [7:0]         exp_byte;
	logic               busy_seen;
	logic               ep_probe;
	logic [WB_DW-1:0]   exp_tx_word;
	logic               led_off;
	logic               pwm_track;
	int                 win_fill;
	int                 hi_cnt [3];
	logic [PWM_WIN-1:0] hist [3];
	logic               boot_chk;
	logic               boot_exp;
	logic [1:0]         sel_exp;
	logic               rd_ack;
	logic               uart_data_sel;

	assign rd_ack        = wb_cyc & wb_ack & ~wb_we;
	assign uart_data_sel = (wb_addr[SLOT_MSB:SLOT_LSB] == SLOT_UART)
		& (wb_addr[1:0] == UART_REG_DATA);

	tb_clk_gen u_clk (
		.clk_o (clk_24m)
	);

	soc_periph_top dut (
		.clk_24m       (clk_24m),
		.rst           (rst),
		.wb_addr_i     (wb_addr),
		.wb_wdata_i    (wb_wdata),
		.wb_we_i       (wb_we),
		.wb_cyc_i      (wb_cyc),
		.wb_rdata_o    (wb_rdata),
		.wb_ack_o      (wb_ack),
		.uart_rx_i     (uart_line),
		.uart_tx_o     (uart_line),
		.btn_i         (btn),
		.rgb_o         (rgb),
		.boot_o        (boot),
		.boot_sel_o    (boot_sel),
		.usb_tx_addr_i (usb_tx_addr),
		.usb_tx_data_o (usb_tx_data),
		.usb_rx_addr_i (usb_rx_addr),
		.usb_rx_data_i (usb_rx_data),
		.usb_rx_we_i   (usb_rx_we)
	);

	a_ack_in_time: assert property (@(posedge clk_24m) disable iff (rst)
		$rose(wb_cyc) |-> ##[0:1] wb_ack)
	else begin
		errors++;
		$display("%t: no ack within 2 cycles for address %h", $time, $sampled(wb_addr));
	end

	a_ack_idle: assert property (@(posedge clk_24m) disable iff (rst) !wb_cyc |-> !wb_ack)
	else begin
		errors++;
		$display("%t: ack is high while cyc is low", $time);
	end

	a_ack_reset: assert property (@(posedge clk_24m) $fell(rst) |-> !wb_ack)
	else begin
		errors++;
		$display("%t: ack is high right after reset", $time);
	end

	a_rdata: assert property (@(posedge clk_24m) disable iff (rst)
		rd_ack && exp_en |-> (wb_rdata & exp_mask) == exp_val)
	else begin
		errors++;
		$display("[FAIL] wb_rdata at %h: got %h, expected %h under mask %h",
			$sampled(wb_addr), $sampled(wb_rdata), $sampled(exp_val), $sampled(exp_mask));
	end

	// A full receive buffer must hold the byte last sent
	a_uart_byte: assert property (@(posedge clk_24m) disable iff (rst)
		rd_ack && uart_data_sel && !wb_rdata[WB_DW-1] |-> wb_rdata[7:0] == exp_byte)
	else begin
		errors++;
		$display("[FAIL] wb_rdata[7:0] UART byte: got %h, expected %h",
			$sampled(wb_rdata[7:0]), $sampled(exp_byte));
	end

	a_uart_idle: assert property (@(posedge clk_24m) disable iff (rst)
		wb_cyc && wb_ack && wb_we && uart_data_sel |-> !busy_seen)
	else begin
		errors++;
		$display("%t: UART byte written while the last poll showed busy", $time);
	end

	a_usb_tx: assert property (@(posedge clk_24m) disable iff (rst)
		ep_probe |=> usb_tx_data == exp_tx_word)
	else begin
		errors++;
		$display("[FAIL] usb_tx_data_o: got %h, expected %h",
			$sampled(usb_tx_data), $sampled(exp_tx_word));
	end

	a_led_off: assert property (@(posedge clk_24m) disable iff (rst) led_off |-> rgb == 3'b000)
	else begin
		errors++;
		$display("[FAIL] rgb_o while disabled: got %h, expected %h", $sampled(rgb), 3'b000);
	end

	for (genvar i = 0; i < 3; i++) begin : g_duty
		a_duty: assert property (@(posedge clk_24m) disable iff (rst)
			win_fill == PWM_WIN |-> hi_cnt[i] == int'(DUTY[i*PWM_W +: PWM_W]))
		else begin
			errors++;
			$display("[FAIL] rgb_o[%0d] high count: got %h, expected %h",
				i, $sampled(hi_cnt[i]), DUTY[i*PWM_W +: PWM_W]);
		end
	end

	a_boot: assert property (@(posedge clk_24m) disable iff (rst) boot_chk |-> boot == boot_exp)
	else begin
		errors++;
		$display("[FAIL] boot_o: got %h, expected %h", $sampled(boot), $sampled(boot_exp));
	end

	a_boot_sel: assert property (@(posedge clk_24m) disable iff (rst)
		boot_chk |-> boot_sel == sel_exp)
	else begin
		errors++;
		$display("[FAIL] boot_sel_o: got %h, expected %h", $sampled(boot_sel), $sampled(sel_exp));
	end

	// Sliding window of the last 256 samples per output
	always @(negedge clk_24m) begin
		if (!pwm_track) begin
			win_fill <= 0;
			for (int i = 0; i < 3; i++) begin
				hi_cnt[i] <= 0;
				hist[i]   <= '0;
			end
		end else begin
			if (win_fill < PWM_WIN)
				win_fill <= win_fill + 1;
			for (int i = 0; i < 3; i++) begin
				hist[i]   <= {hist[i][PWM_WIN-2:0], rgb[i]};
				hi_cnt[i] <= hi_cnt[i] + int'(rgb[i]) - int'(hist[i][PWM_WIN-1]);
			end
		end
	end

	function automatic logic [WB_DW-1:0] rand_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [WB_AW-1:0] slot_addr(input logic [SLOT_W-1:0] slot,
			input logic [SLV_AW-1:0] off);
		return WB_AW'({slot, off});
	endfunction

	task automatic hold_reset();
		@(posedge clk_24m);
		#DRV_DLY;
		rst = 1'b1;
		repeat (RST_CYC) @(posedge clk_24m);
		#DRV_DLY;
		rst = 1'b0;
	endtask

	task automatic bus_xfer(input logic we, input logic [WB_AW-1:0] addr,
			input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk_24m);
		#DRV_DLY;
		wb_addr  = addr;
		wb_we    = we;
		wb_wdata = wdata;
		wb_cyc   = 1'b1;
		// Ack is looked at mid-cycle, the transfer ends on the next edge
		do begin
			@(negedge clk_24m);
			waited++;
		end while (!wb_ack && waited < ACK_MAX);
		if (!wb_ack) begin
			errors++;
			$display("%t: bus transfer to %h was never acknowledged", $time, addr);
		end
		rdata = wb_rdata;
		xfers++;
		@(posedge clk_24m);
		#DRV_DLY;
		wb_cyc = 1'b0;
		exp_en = 1'b0;
	endtask

	task automatic bus_write(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] data);
		logic [WB_DW-1:0] rd_dummy;
		bus_xfer(1'b1, addr, data, rd_dummy);
	endtask

	task automatic bus_read(input logic [WB_AW-1:0] addr, output logic [WB_DW-1:0] data);
		bus_xfer(1'b0, addr, '0, data);
	endtask

	task automatic bus_check(input logic [WB_AW-1:0] addr, input logic [WB_DW-1:0] mask,
			input logic [WB_DW-1:0] val);
		logic [WB_DW-1:0] data;
		exp_mask = mask;
		exp_val  = val;
		exp_en   = 1'b1;
		bus_read(addr, data);
	endtask

	task automatic uart_wait_idle();
		logic [WB_DW-1:0] st;
		int polls;
		polls = 0;
		do begin
			bus_read(slot_addr(SLOT_UART, UART_REG_DATA), st);
			polls++;
		end while (st[WB_DW-2] && polls < POLL_MAX);
		busy_seen = st[WB_DW-2];
	endtask

	task automatic uart_wait_rx();
		logic [WB_DW-1:0] st;
		int polls;
		polls = 0;
		do begin
			bus_read(slot_addr(SLOT_UART, UART_REG_DATA), st);
			polls++;
		end while (st[WB_DW-1] && polls < POLL_MAX);
		if (st[WB_DW-1]) begin
			errors++;
			$display("%t: UART loopback byte never arrived", $time);
		end
	endtask

	initial begin
		#(WDOG_NS);
		errors++;
		$display("Watchdog expired after %0d ns, tests did not finish", WDOG_NS);
		$display("transfers %0d, errors %0d", xfers, errors);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic [WB_DW-1:0]  word;
		logic [EP_AW-1:0]  ep_addr;
		logic [SLV_AW-1:0] off;
		int                waited;
		rst         = 1'b1;
		wb_addr     = '0;
		wb_wdata    = '0;
		wb_we       = 1'b0;
		wb_cyc      = 1'b0;
		btn         = 1'b0;
		usb_tx_addr = '0;
		usb_rx_addr = '0;
		usb_rx_data = '0;
		usb_rx_we   = 1'b0;
		errors      = 0;
		xfers       = 0;
		lcg_state   = 32'd65;
		exp_en      = 1'b0;
		exp_mask    = '0;
		exp_val     = '0;
		exp_byte    = '0;
		busy_seen   = 1'b0;
		ep_probe    = 1'b0;
		exp_tx_word = '0;
		led_off     = 1'b1;
		pwm_track   = 1'b0;
		boot_chk    = 1'b0;
		boot_exp    = 1'b0;
		sel_exp     = '0;
		hold_reset();

		// Unmapped slots read as zero
		bus_check(slot_addr(3'd2, '0), '1, '0);
		bus_check(slot_addr(3'd7, 12'h0a5), '1, '0);

		// UART loopback
		bus_write(slot_addr(SLOT_UART, UART_REG_DIV), UART_DIV);
		bus_check(slot_addr(SLOT_UART, UART_REG_DIV), '1, UART_DIV);
		for (int n = 0; n < 3; n++) begin
			word = rand_word();
			uart_wait_idle();
			exp_byte = word[23:16];
			bus_write(slot_addr(SLOT_UART, UART_REG_DATA), {24'h0, word[23:16]});
			uart_wait_rx();
		end
		bus_check(slot_addr(SLOT_UART, UART_REG_DATA), 32'h8000_0000, 32'h8000_0000);

		// Endpoint buffer, bus to USB
		word    = rand_word();
		ep_addr = word[EP_AW-1:0];
		word    = rand_word();
		bus_write(slot_addr(SLOT_EP, SLV_AW'(ep_addr)), word);
		bus_check(slot_addr(SLOT_EP, SLV_AW'(ep_addr)), '1, word);
		@(posedge clk_24m);
		#DRV_DLY;
		usb_tx_addr = ep_addr;
		exp_tx_word = word;
		ep_probe    = 1'b1;
		@(posedge clk_24m);
		#DRV_DLY;
		ep_probe    = 1'b0;
		usb_tx_addr = ep_addr + 1'b1;

		// Endpoint buffer, USB to bus
		word        = rand_word();
		ep_addr     = word[EP_AW-1:0];
		word        = rand_word();
		usb_rx_addr = ep_addr;
		usb_rx_data = word;
		usb_rx_we   = 1'b1;
		@(posedge clk_24m);
		#DRV_DLY;
		usb_rx_we = 1'b0;
		off       = '0;
		off[EP_RX_SEL]   = 1'b1;
		off[EP_AW-1:0]   = ep_addr;
		bus_check(slot_addr(SLOT_EP, off), '1, word);

		// LED PWM
		for (int i = 0; i < 3; i++)
			bus_write(slot_addr(SLOT_LED, SLV_AW'(16 + i)), WB_DW'(DUTY[i*PWM_W +: PWM_W]));
		repeat (LED_OFF_CYC) @(posedge clk_24m);
		#DRV_DLY;
		led_off = 1'b0;
		bus_write(slot_addr(SLOT_LED, '0), 32'h4);
		pwm_track = 1'b1;
		bus_check(slot_addr(SLOT_LED, '0), '1, 32'h4);
		repeat (3 * PWM_WIN) @(posedge clk_24m);
		#DRV_DLY;
		pwm_track = 1'b0;

		// Boot request from the bus
		bus_write(slot_addr(SLOT_BOOT, '0), 32'h6);
		boot_exp = 1'b1;
		sel_exp  = 2'd2;
		boot_chk = 1'b1;
		bus_check(slot_addr(SLOT_BOOT, '0), '1, 32'h6);
		boot_chk = 1'b0;
		hold_reset();

		// Short press must not boot
		boot_exp = 1'b0;
		sel_exp  = 2'd0;
		boot_chk = 1'b1;
		btn      = 1'b1;
		repeat (SHORT_CYC) @(posedge clk_24m);
		#DRV_DLY;
		btn = 1'b0;
		repeat (100) @(posedge clk_24m);
		#DRV_DLY;
		boot_chk = 1'b0;

		// Long press
		btn    = 1'b1;
		waited = 0;
		while (!boot && waited < LONG_MAX) begin
			@(negedge clk_24m);
			waited++;
		end
		if (!boot) begin
			errors++;
			$display("%t: long press did not raise boot_o", $time);
		end else if (waited < BTN_LONG) begin
			errors++;
			$display("%t: boot_o rose after only %0d cycles of press", $time, waited);
		end
		@(posedge clk_24m);
		#DRV_DLY;
		boot_exp = 1'b1;
		sel_exp  = BTN_BOOT_SEL;
		boot_chk = 1'b1;
		repeat (20) @(posedge clk_24m);
		#DRV_DLY;
		btn = 1'b0;
		repeat (40) @(posedge clk_24m);
		#DRV_DLY;
		boot_chk = 1'b0;

		repeat (5) @(posedge clk_24m);
		$display("transfers %0d, errors %0d", xfers, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/soc_pkg.sv
hdl/wb_slot_decode.sv
hdl/uart_wb.sv
hdl/led_pwm_wb.sv
hdl/boot_ctrl_wb.sv
hdl/ep_buffer_wb.sv
hdl/soc_periph_top.sv
dv/tb_clk_gen.sv
dv/tb_soc_periph.sv
